// ==== verilog.f ====
+incdir+hw
hw/scrmbl_cmd_pkg.sv
hw/scrmbl_const_pkg.sv
hw/present_round.sv
hw/scrmbl_round_cnt.sv
hw/scrmbl_fsm.sv
hw/scrmbl_datapath.sv
hw/scrmbl_top.sv
verification/scrmbl_assert.sv
verification/scrmbl_tb.sv

// ==== verification/scrmbl_tb.sv ====
// self-checking testbench for scrmbl_top
// expected values come from a PRESENT-128 model and the fixed tables
// results are matched in order of issue, one command in flight
`timescale 1ns/1ps
`include "scrmbl_params.svh"

module scrmbl_tb
  import scrmbl_cmd_pkg::*;
  import scrmbl_const_pkg::*;
();

  localparam int Timeout = 200;
  localparam int Rounds  = `SCRMBL_ROUNDS;
  // PRESENT sbox, entry n holds S(n)
  localparam logic [3:0] PresentSbox [16] = '{
    4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
    4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
  };

  logic                     clk;
  logic                     rst_n;
  scrmbl_cmd_e              cmd;
  digest_mode_e             mode;
  logic [`SCRMBL_SEL_W-1:0] sel;
  block_t                   data_in;
  logic                     valid_in;
  logic                     ready;
  block_t                   data_out;
  logic                     valid_out;

  integer seed;
  int     mism_errs;
  int     other_errs;
  logic   timed_out;
  // pending results in order of issue
  block_t exp_q[$];
  string  name_q[$];

  initial clk = 1'b0;
  always #5 clk = ~clk;

  scrmbl_top dut (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .cmd_i  (cmd),
    .mode_i (mode),
    .sel_i  (sel),
    .data_i (data_in),
    .valid_i(valid_in),
    .ready_o(ready),
    .data_o (data_out),
    .valid_o(valid_out)
  );

  ////////////////////
  // reference model
  ////////////////////

  // full 31 round PRESENT-128 encryption with final whitening
  function automatic block_t present_enc(input key_t key, input block_t pt);
    block_t     st;
    block_t     sub;
    block_t     perm;
    key_t       k;
    logic [4:0] rc;
    st = pt;
    k  = key;
    for (int r = 1; r <= Rounds; r++) begin
      st = st ^ k[127:64];
      for (int n = 0; n < 16; n++) begin
        sub[4*n +: 4] = PresentSbox[st[4*n +: 4]];
      end
      // bit i goes to 16*(i mod 4) + i/4
      for (int i = 0; i < 64; i++) begin
        perm[16*(i % 4) + i/4] = sub[i];
      end
      st = perm;
      k  = (k << 61) | (k >> 67);
      k[127:124] = PresentSbox[k[127:124]];
      k[123:120] = PresentSbox[k[123:120]];
      rc = r[4:0];
      k[66:62] = k[66:62] ^ rc;
    end
    return st ^ k[127:64];
  endfunction

  function automatic block_t rand_block();
    block_t r;
    r[63:32] = $random(seed);
    r[31:0]  = $random(seed);
    return r;
  endfunction

  ////////////////////
  // checks and commands
  ////////////////////

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      mism_errs++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready && !timed_out && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!ready && !timed_out) begin
      other_errs++;
      $display("Error: ready_o stayed low for %0d cycles", Timeout);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_cmd(input string name, input scrmbl_cmd_e c, input digest_mode_e m,
                         input logic [`SCRMBL_SEL_W-1:0] s, input block_t d,
                         input block_t exp);
    int   cycles;
    logic round_cmd;
    round_cmd = (c == Encrypt) || (c == Digest) || (c == DigestFinalize);
    wait_ready();
    if (!timed_out) begin
      if (round_cmd) begin
        exp_q.push_back(exp);
        name_q.push_back(name);
      end
      cmd      = c;
      mode     = m;
      sel      = s;
      data_in  = d;
      valid_in = 1'b1;
      @(negedge clk);
      valid_in = 1'b0;
      cmd      = CmdUnused;
      data_in  = '0;
      if (round_cmd) begin
        // count round edges, ready_o must stay low meanwhile
        cycles = 0;
        while (!valid_out && cycles < Timeout) begin
          check({name, " ready"}, 64'd0, ready);
          @(negedge clk);
          cycles++;
        end
        if (!valid_out) begin
          other_errs++;
          $display("Error: %s gave no valid_o within %0d cycles", name, Timeout);
          timed_out = 1'b1;
        end else begin
          check({name, " latency"}, Rounds, cycles);
          check({name, " ready at result"}, 64'd1, ready);
        end
      end else begin
        check({name, " ready"}, 64'd1, ready);
      end
    end
  endtask

  // every valid_o pulse must match the oldest pending result
  always @(negedge clk) begin : compare_out
    block_t exp_val;
    string  exp_name;
    if (rst_n && valid_out) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Error: valid_o pulse with no result pending");
      end else begin
        exp_val  = exp_q.pop_front();
        exp_name = name_q.pop_front();
        check(exp_name, exp_val, data_out);
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    block_t a;
    block_t b;
    block_t e1;
    block_t e2;
    block_t dig;
    block_t fin;
    seed       = 32'h7d78_9563;
    mism_errs  = 0;
    other_errs = 0;
    timed_out  = 1'b0;
    rst_n      = 1'b0;
    cmd        = CmdUnused;
    mode       = StandardMode;
    sel        = '0;
    data_in    = '0;
    valid_in   = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("reset ready", 64'd1, ready);
    check("reset valid", 64'd0, valid_out);

    // encrypt with every key, timing checked inside run_cmd
    for (int s = 0; s < `SCRMBL_NUM_KEYS; s++) begin
      a = rand_block();
      run_cmd($sformatf("encrypt sel %0d", s), Encrypt, StandardMode,
              s[`SCRMBL_SEL_W-1:0], a, present_enc(ScrmblKeys[s], a));
    end

    // standard digest and finalize on both sets
    for (int s = 0; s < `SCRMBL_NUM_DIGEST; s++) begin
      a   = rand_block();
      b   = rand_block();
      dig = present_enc({b, a}, DigestIv[s]) ^ DigestIv[s];
      fin = present_enc(DigestConst[s], dig) ^ dig;
      run_cmd("digest init", DigestInit, StandardMode, s[`SCRMBL_SEL_W-1:0], '0, '0);
      run_cmd("load shadow", LoadShadow, StandardMode, '0, a, '0);
      run_cmd($sformatf("digest set %0d", s), Digest, StandardMode, '0, b, dig);
      run_cmd($sformatf("finalize set %0d", s), DigestFinalize, StandardMode,
              s[`SCRMBL_SEL_W-1:0], '0, fin);
    end

    // chained digest, key block is {second result, first result}
    a   = rand_block();
    b   = rand_block();
    e1  = present_enc(ScrmblKeys[2], a);
    e2  = present_enc(ScrmblKeys[3], b);
    dig = present_enc({e2, e1}, DigestIv[1]) ^ DigestIv[1];
    fin = present_enc(DigestConst[1], dig) ^ dig;
    run_cmd("chained init", DigestInit, ChainedMode, 2'd1, '0, '0);
    run_cmd("chained encrypt 1", Encrypt, StandardMode, 2'd2, a, e1);
    run_cmd("chained shadow", LoadShadow, StandardMode, '0, rand_block(), '0);
    run_cmd("chained encrypt 2", Encrypt, StandardMode, 2'd3, b, e2);
    run_cmd("chained digest", Digest, StandardMode, '0, rand_block(), dig);
    run_cmd("chained finalize", DigestFinalize, StandardMode, 2'd1, '0, fin);

    // finalize drops back to standard mode, chaining from the last value
    a   = rand_block();
    b   = rand_block();
    dig = present_enc({b, a}, fin) ^ fin;
    run_cmd("post finalize shadow", LoadShadow, ChainedMode, '0, a, '0);
    run_cmd("post finalize digest", Digest, ChainedMode, '0, b, dig);

    // an encrypt between digest and finalize leaves the digest alone
    a   = rand_block();
    b   = rand_block();
    dig = present_enc({b, a}, DigestIv[0]) ^ DigestIv[0];
    fin = present_enc(DigestConst[0], dig) ^ dig;
    run_cmd("interleave init", DigestInit, StandardMode, 2'd0, '0, '0);
    run_cmd("interleave shadow", LoadShadow, StandardMode, '0, a, '0);
    run_cmd("interleave digest", Digest, StandardMode, '0, b, dig);
    a = rand_block();
    run_cmd("interleave encrypt", Encrypt, StandardMode, 2'd1, a,
            present_enc(ScrmblKeys[1], a));
    run_cmd("interleave finalize", DigestFinalize, StandardMode, 2'd0, '0, fin);

    wait_ready();
    @(negedge clk);
    if (!timed_out && exp_q.size() != 0) begin
      other_errs++;
      $display("Error: %0d results never arrived", exp_q.size());
    end
    $display("Errors: %0d mismatches, %0d other failures", mism_errs, other_errs);
    if (mism_errs == 0 && other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verification/scrmbl_assert.sv ====
// protocol checks on the scrmbl_top ports, bound into every scrmbl_top
// assumes one round command in flight at a time
`timescale 1ns/1ps

module scrmbl_assert
  import scrmbl_cmd_pkg::*;
  import scrmbl_const_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input scrmbl_cmd_e cmd_i,
  input logic        valid_i,
  input logic        ready_o,
  input block_t      data_o,
  input logic        valid_o
);

  logic round_accept;
  logic busy_q;

  // only these commands run the cipher rounds
  assign round_accept = ready_o && valid_i &&
                        (cmd_i == Encrypt || cmd_i == Digest || cmd_i == DigestFinalize);

  // set on an accepted round command, cleared by the result pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_busy
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (round_accept) begin
      busy_q <= 1'b1;
    end else if (valid_o) begin
      busy_q <= 1'b0;
    end
  end

  a_valid_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o)
    else $error("valid_o high for two cycles in a row");

  a_data_zero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_o |-> (data_o == '0))
    else $error("data_o not zero while valid_o is low");

  a_busy_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (busy_q && !valid_o) |-> !ready_o)
    else $error("ready_o high while a round command is running");

endmodule

bind scrmbl_top scrmbl_assert u_assert (.*);

// ==== hw/scrmbl_top.sv ====
// OTP scrambling datapath, PRESENT-128 encrypt and 128-bit digest
// one round per cycle, ready_o only in idle, no output back-pressure
// valid_o pulses one cycle, SCRMBL_ROUNDS edges after a round command
`timescale 1ns/1ps
`include "scrmbl_params.svh"

module scrmbl_top
  import scrmbl_cmd_pkg::*;
  import scrmbl_const_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  scrmbl_cmd_e              cmd_i,
  input  digest_mode_e             mode_i,
  input  logic [`SCRMBL_SEL_W-1:0] sel_i,
  input  block_t                   data_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output block_t                   data_o,
  output logic                     valid_o
);

  // sequencer controls
  data_sel_e data_sel;
  key_sel_e  key_sel;
  logic      data_en, key_en;
  logic      shadow_copy, shadow_load;
  logic      digest_en, digest_init;
  logic      last_round;

  // round counter
  logic                     cnt_clr, cnt_en, cnt_last;
  logic [`SCRMBL_CNT_W-1:0] cnt;

  // round unit in and out
  block_t data_state, round_data;
  key_t   key_state, round_key;

  scrmbl_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_i),
    .mode_i       (mode_i),
    .valid_i      (valid_i),
    .cnt_last_i   (cnt_last),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .cnt_clr_o    (cnt_clr),
    .cnt_en_o     (cnt_en),
    .data_sel_o   (data_sel),
    .key_sel_o    (key_sel),
    .data_en_o    (data_en),
    .key_en_o     (key_en),
    .shadow_copy_o(shadow_copy),
    .shadow_load_o(shadow_load),
    .digest_en_o  (digest_en),
    .digest_init_o(digest_init),
    .last_round_o (last_round)
  );

  scrmbl_round_cnt u_round_cnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (cnt_clr),
    .en_i      (cnt_en),
    .cnt_o     (cnt),
    .cnt_last_o(cnt_last)
  );

  scrmbl_datapath u_datapath (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_i       (data_i),
    .sel_i        (sel_i),
    .data_sel_i   (data_sel),
    .key_sel_i    (key_sel),
    .data_en_i    (data_en),
    .key_en_i     (key_en),
    .shadow_copy_i(shadow_copy),
    .shadow_load_i(shadow_load),
    .digest_en_i  (digest_en),
    .digest_init_i(digest_init),
    .valid_i      (valid_o),
    .round_data_i (round_data),
    .round_key_i  (round_key),
    .data_state_o (data_state),
    .key_state_o  (key_state),
    .data_o       (data_o)
  );

  present_round u_present_round (
    .data_i(data_state),
    .key_i (key_state),
    .cnt_i (cnt),
    .last_i(last_round),
    .data_o(round_data),
    .key_o (round_key)
  );

endmodule

// ==== hw/scrmbl_datapath.sv ====
// working registers of the scrambling datapath
// digest sets are indexed by the low bits of sel_i only
// data_o is forced to zero outside the valid pulse
`timescale 1ns/1ps
`include "scrmbl_params.svh"

module scrmbl_datapath
  import scrmbl_cmd_pkg::*;
  import scrmbl_const_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  block_t                   data_i,
  input  logic [`SCRMBL_SEL_W-1:0] sel_i,
  input  data_sel_e                data_sel_i,
  input  key_sel_e                 key_sel_i,
  input  logic                     data_en_i,
  input  logic                     key_en_i,
  input  logic                     shadow_copy_i,
  input  logic                     shadow_load_i,
  input  logic                     digest_en_i,
  input  logic                     digest_init_i,
  input  logic                     valid_i,
  input  block_t                   round_data_i,
  input  key_t                     round_key_i,
  output block_t                   data_state_o,
  output key_t                     key_state_o,
  output block_t                   data_o
);

  localparam int DigestSelW = $clog2(`SCRMBL_NUM_DIGEST);

  key_t   key_state_d, key_state_q;
  block_t data_state_d, data_state_q;
  block_t data_shadow_q;
  block_t digest_state_d, digest_state_q;
  block_t round_data_xor;
  key_t   enc_key_mux;
  key_t   digest_const_mux;
  block_t digest_iv_mux;

  ////////////////////
  // table selection
  ////////////////////

  assign enc_key_mux      = ScrmblKeys[sel_i];
  assign digest_const_mux = DigestConst[sel_i[DigestSelW-1:0]];
  assign digest_iv_mux    = DigestIv[sel_i[DigestSelW-1:0]];

  // Davies-Meyer feed forward
  assign round_data_xor = round_data_i ^ digest_state_q;

  always_comb begin : p_data_mux
    case (data_sel_i)
      SelEncDataOut:    data_state_d = round_data_i;
      SelEncDataOutXor: data_state_d = round_data_xor;
      SelDigestState:   data_state_d = digest_state_q;
      default:          data_state_d = data_i;
    endcase
  end

  // digest blocks, new data on top and shadow below
  always_comb begin : p_key_mux
    case (key_sel_i)
      SelEncKeyOut:     key_state_d = round_key_i;
      SelEncKeyInit:    key_state_d = enc_key_mux;
      SelDigestConst:   key_state_d = digest_const_mux;
      SelDigestChained: key_state_d = {data_state_q, data_shadow_q};
      default:          key_state_d = {data_i, data_shadow_q};
    endcase
  end

  // IV on init, chaining value otherwise
  assign digest_state_d = digest_init_i ? digest_iv_mux : round_data_xor;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      key_state_q    <= '0;
      data_state_q   <= '0;
      data_shadow_q  <= '0;
      digest_state_q <= '0;
    end else begin
      if (key_en_i) begin
        key_state_q <= key_state_d;
      end
      if (data_en_i) begin
        data_state_q <= data_state_d;
      end
      // chained mode copies the last encrypt result
      if (shadow_copy_i) begin
        data_shadow_q <= data_state_q;
      end else if (shadow_load_i) begin
        data_shadow_q <= data_i;
      end
      if (digest_en_i) begin
        digest_state_q <= digest_state_d;
      end
    end
  end

  assign data_state_o = data_state_q;
  assign key_state_o  = key_state_q;
  assign data_o       = valid_i ? data_state_q : '0;

endmodule

// ==== hw/scrmbl_fsm.sv ====
// command decoder and round sequencer
// commands are taken only in idle, one operation in flight at a time
// LoadShadow and DigestInit finish on the accepting edge without valid_o
`timescale 1ns/1ps

module scrmbl_fsm
  import scrmbl_cmd_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  scrmbl_cmd_e  cmd_i,
  input  digest_mode_e mode_i,
  input  logic         valid_i,
  input  logic         cnt_last_i,
  output logic         ready_o,
  output logic         valid_o,
  output logic         cnt_clr_o,
  output logic         cnt_en_o,
  output data_sel_e    data_sel_o,
  output key_sel_e     key_sel_o,
  output logic         data_en_o,
  output logic         key_en_o,
  output logic         shadow_copy_o,
  output logic         shadow_load_o,
  output logic         digest_en_o,
  output logic         digest_init_o,
  output logic         last_round_o
);

  state_e       state_d, state_q;
  digest_mode_e digest_mode_d, digest_mode_q;
  logic         valid_d, valid_q;

  always_comb begin : p_fsm
    state_d       = state_q;
    digest_mode_d = digest_mode_q;
    valid_d       = 1'b0;
    ready_o       = 1'b0;
    cnt_clr_o     = 1'b0;
    cnt_en_o      = 1'b0;
    data_sel_o    = SelDataInput;
    key_sel_o     = SelDigestInput;
    data_en_o     = 1'b0;
    key_en_o      = 1'b0;
    shadow_copy_o = 1'b0;
    shadow_load_o = 1'b0;
    digest_en_o   = 1'b0;
    digest_init_o = 1'b0;
    last_round_o  = 1'b0;

    case (state_q)
      ////////////////////
      // idle, decode and load working registers
      IdleSt: begin
        ready_o   = 1'b1;
        cnt_clr_o = 1'b1;
        if (valid_i) begin
          case (cmd_i)
            Encrypt: begin
              state_d   = EncryptSt;
              key_sel_o = SelEncKeyInit;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            LoadShadow: begin
              // chained mode keeps the previous encryption result
              if (digest_mode_q == ChainedMode) begin
                shadow_copy_o = 1'b1;
              end else begin
                shadow_load_o = 1'b1;
              end
            end
            Digest: begin
              state_d    = DigestSt;
              data_sel_o = SelDigestState;
              key_sel_o  = (digest_mode_q == ChainedMode) ? SelDigestChained : SelDigestInput;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            DigestInit: begin
              digest_mode_d = mode_i;
              digest_init_o = 1'b1;
              digest_en_o   = 1'b1;
            end
            DigestFinalize: begin
              state_d       = DigestSt;
              data_sel_o    = SelDigestState;
              key_sel_o     = SelDigestConst;
              data_en_o     = 1'b1;
              key_en_o      = 1'b1;
              digest_mode_d = StandardMode;
            end
            default: begin
              // unused code, nothing happens
            end
          endcase
        end
      end
      ////////////////////
      // cipher rounds
      EncryptSt: begin
        data_sel_o   = SelEncDataOut;
        key_sel_o    = SelEncKeyOut;
        data_en_o    = 1'b1;
        key_en_o     = 1'b1;
        cnt_en_o     = 1'b1;
        last_round_o = cnt_last_i;
        if (cnt_last_i) begin
          state_d = IdleSt;
          valid_d = 1'b1;
        end
      end
      ////////////////////
      // Davies-Meyer step on the same rounds
      DigestSt: begin
        data_sel_o   = SelEncDataOut;
        key_sel_o    = SelEncKeyOut;
        data_en_o    = 1'b1;
        key_en_o     = 1'b1;
        cnt_en_o     = 1'b1;
        last_round_o = cnt_last_i;
        if (cnt_last_i) begin
          state_d     = IdleSt;
          valid_d     = 1'b1;
          // feed forward and keep a copy, encrypts may come in between
          data_sel_o  = SelEncDataOutXor;
          digest_en_o = 1'b1;
        end
      end
      default: begin
        state_d = IdleSt;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= IdleSt;
      digest_mode_q <= StandardMode;
      valid_q       <= 1'b0;
    end else begin
      state_q       <= state_d;
      digest_mode_q <= digest_mode_d;
      valid_q       <= valid_d;
    end
  end

  // one cycle pulse after the last round edge
  assign valid_o = valid_q;

endmodule

// ==== hw/scrmbl_round_cnt.sv ====
// round counter for the iterative cipher
// clr_i wins over en_i, the count does not wrap on its own
`timescale 1ns/1ps
`include "scrmbl_params.svh"

module scrmbl_round_cnt (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clr_i,
  input  logic                     en_i,
  output logic [`SCRMBL_CNT_W-1:0] cnt_o,
  output logic                     cnt_last_o
);

  localparam int unsigned LastRoundInt = `SCRMBL_ROUNDS - 1;
  localparam logic [`SCRMBL_CNT_W-1:0] LastRound = LastRoundInt[`SCRMBL_CNT_W-1:0];

  logic [`SCRMBL_CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (en_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign cnt_o = cnt_q;

  // high during the final round cycle
  assign cnt_last_o = (cnt_q == LastRound);

endmodule

// ==== hw/present_round.sv ====
// single PRESENT-128 encryption round, purely combinational
// cnt_i counts from 0, the schedule uses round number cnt_i + 1
// last_i adds the final whitening key to the data output
`timescale 1ns/1ps
`include "scrmbl_params.svh"

module present_round
  import scrmbl_const_pkg::*;
(
  input  block_t                   data_i,
  input  key_t                     key_i,
  input  logic [`SCRMBL_CNT_W-1:0] cnt_i,
  input  logic                     last_i,
  output block_t                   data_o,
  output key_t                     key_o
);

  // 4-bit sbox, nibble n holds S(n)
  localparam logic [15:0][3:0] Sbox = 64'h2174_8FE3_DA09_B65C;

  block_t                   state_key;
  block_t                   state_sub;
  block_t                   state_perm;
  key_t                     key_rot;
  key_t                     key_next;
  logic [`SCRMBL_CNT_W-1:0] round_idx;

  ////////////////////
  // data path
  ////////////////////

  // add round key, upper half of the key register
  assign state_key = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

  // substitution layer on all 16 nibbles
  always_comb begin : p_sbox
    for (int i = 0; i < 16; i++) begin
      state_sub[4*i +: 4] = Sbox[state_key[4*i +: 4]];
    end
  end

  // bit i moves to 16*i mod 63, bit 63 stays put
  always_comb begin : p_perm
    for (int i = 0; i < 63; i++) begin
      state_perm[(16*i) % 63] = state_sub[i];
    end
    state_perm[63] = state_sub[63];
  end

  ////////////////////
  // key schedule
  ////////////////////

  assign round_idx = cnt_i + 1'b1;

  // rotate left by 61
  assign key_rot = {key_i[66:0], key_i[127:67]};

  always_comb begin : p_key
    key_next          = key_rot;
    // top two nibbles through the sbox
    key_next[127:124] = Sbox[key_rot[127:124]];
    key_next[123:120] = Sbox[key_rot[123:120]];
    // round counter xor
    key_next[66:62]   = key_rot[66:62] ^ round_idx;
  end

  assign key_o = key_next;

  // final whitening after round 31
  assign data_o = last_i ? (state_perm ^ key_next[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W])
                         : state_perm;

endmodule

// ==== hw/scrmbl_const_pkg.sv ====
// data types and netlist constants of the scrambling datapath
// keys, finalization constants and IVs are fixed at build time
// table sizes follow scrmbl_params.svh
`include "scrmbl_params.svh"

package scrmbl_const_pkg;

  typedef logic [`SCRMBL_BLOCK_W-1:0] block_t;
  typedef logic [`SCRMBL_KEY_W-1:0] key_t;

  ////////////////////
  // encryption keys
  ////////////////////

  // index is sel_i on Encrypt
  localparam key_t ScrmblKeys [`SCRMBL_NUM_KEYS] = '{
    128'h3BA7_16F2_9C05_E48D_7A61_0FC3_B829_5D4E,
    128'h91E4_0A7C_D352_6B18_F0A9_2C74_E6B3_0D85,
    128'hC58F_2E93_47A1_B60D_18E7_5F3C_02D9_A46B,
    128'h6D02_B9F1_85CE_347A_E19B_C063_7F48_2A15
  };

  ////////////////////
  // digest sets
  ////////////////////

  // finalization constants, used as cipher key on DigestFinalize
  localparam key_t DigestConst [`SCRMBL_NUM_DIGEST] = '{
    128'hA4F8_3C17_05D2_E96B_8C31_7BE0_4F92_D65A,
    128'h1E6C_D08B_72F5_A943_35BA_E17C_9804_6FD2
  };

  // initial chaining values, loaded on DigestInit
  localparam block_t DigestIv [`SCRMBL_NUM_DIGEST] = '{
    64'h7C29_E0B4_5A13_F86D,
    64'hD3E5_618F_0B72_C49A
  };

endpackage

// ==== hw/scrmbl_cmd_pkg.sv ====
// control encodings for the scrambling datapath
// code 3'h0 carries no command and is ignored by the FSM
package scrmbl_cmd_pkg;

  // commands accepted in idle
  typedef enum logic [2:0] {
    CmdUnused      = 3'h0,
    Encrypt        = 3'h1,
    LoadShadow     = 3'h2,
    Digest         = 3'h3,
    DigestInit     = 3'h4,
    DigestFinalize = 3'h5
  } scrmbl_cmd_e;

  // chained mode builds the digest block from the last two encryptions
  typedef enum logic {
    StandardMode = 1'b0,
    ChainedMode  = 1'b1
  } digest_mode_e;

  // sequencer states, the spare code falls back to idle
  typedef enum logic [1:0] {
    IdleSt    = 2'h0,
    EncryptSt = 2'h1,
    DigestSt  = 2'h2
  } state_e;

  // data state register source
  typedef enum logic [1:0] {
    SelEncDataOut    = 2'h0,
    SelEncDataOutXor = 2'h1,
    SelDigestState   = 2'h2,
    SelDataInput     = 2'h3
  } data_sel_e;

  // key state register source
  typedef enum logic [2:0] {
    SelEncKeyOut     = 3'h0,
    SelEncKeyInit    = 3'h1,
    SelDigestConst   = 3'h2,
    SelDigestInput   = 3'h3,
    SelDigestChained = 3'h4
  } key_sel_e;

endpackage

// ==== hw/scrmbl_params.svh ====
// sizing for the OTP scrambling datapath
// the round logic is PRESENT-128 only, so block and key widths are fixed
// SCRMBL_CNT_W has to hold SCRMBL_ROUNDS - 1
`ifndef SCRMBL_PARAMS_SVH
`define SCRMBL_PARAMS_SVH

// data block and cipher key
`define SCRMBL_BLOCK_W 64
`define SCRMBL_KEY_W 128

// iterative cipher, one round per cycle
`define SCRMBL_ROUNDS 31
`define SCRMBL_CNT_W 5

// fixed key table and digest constant / IV sets
`define SCRMBL_NUM_KEYS 4
`define SCRMBL_NUM_DIGEST 2

// sel_i indexes the key table, its lsbs index the digest sets
`define SCRMBL_SEL_W 2

`endif
